//--- hw/pio_pkg.sv
`default_nettype none

package pio_pkg;

  localparam int INSTR_W = 16;
  localparam int ADDR_W  = 5;
  localparam int DATA_W  = 32;

  // Instruction fields
  localparam int DELAY_W = 5;
  localparam int OP1_W   = 3;
  localparam int OP2_W   = 5;

  typedef enum logic [2:0] {
    JMP      = 3'd0,
    WAIT     = 3'd1,
    IN       = 3'd2,
    OUT      = 3'd3,
    PUSHPULL = 3'd4,
    MOV      = 3'd5,
    IRQ      = 3'd6,  // Executes as a no-op
    SET      = 3'd7
  } opcode_t;

  // Source and destination selector for IN, OUT, MOV and SET
  typedef enum logic [2:0] {
    PINS    = 3'd0,
    X       = 3'd1,
    Y       = 3'd2,
    NULL    = 3'd3,
    PINDIRS = 3'd4,
    ISR     = 3'd6,
    OSR     = 3'd7
  } src_dst_t;

  typedef enum logic [1:0] {
    NONE    = 2'd0,
    INVERT  = 2'd1,
    REVERSE = 2'd2
  } mov_op_t;

endpackage

`default_nettype wire

//--- hw/pio_divider.sv
`timescale 1ns/100ps
`default_nettype none

module pio_divider (
  input  logic        clk,
  input  logic        reset,
  input  logic [23:0] div,     // 16.8 fixed point
  output logic        penable
);

  logic [23:0] acc;
  logic [24:0] sum;

  // One clock is 1.0, i.e. 256 in 16.8 format
  assign sum = {1'b0, acc} + 25'd256;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc     <= '0;
      penable <= 1'b0;
    end else if (sum >= {1'b0, div}) begin
      // Integer part wrapped, keep the fraction
      acc     <= 24'(sum - {1'b0, div});
      penable <= 1'b1;
    end else begin
      acc     <= sum[23:0];
      penable <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/pio_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module pio_decoder (
  input  logic [pio_pkg::INSTR_W-1:0] instr,
  output pio_pkg::opcode_t            op,
  output logic [pio_pkg::OP1_W-1:0]   op1,
  output logic [pio_pkg::OP2_W-1:0]   op2,
  output logic [pio_pkg::DELAY_W-1:0] delay,
  output logic [5:0]                  bit_count
);

  assign op    = pio_pkg::opcode_t'(instr[15:13]);
  assign delay = instr[12:8];
  assign op1   = instr[7:5];  // Condition or selector
  assign op2   = instr[4:0];  // Index, count or immediate

  // A count of zero means a full word
  assign bit_count = (op2 == '0) ? 6'd32 : {1'b0, op2};

endmodule

`default_nettype wire

//--- hw/pio_pc.sv
`timescale 1ns/100ps
`default_nettype none

module pio_pc (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       penable,
  input  logic                       en,
  input  logic                       jmp,
  input  logic                       stalled,
  input  logic [pio_pkg::ADDR_W-1:0] din,
  input  logic [pio_pkg::ADDR_W-1:0] wrap_end,
  output logic [pio_pkg::ADDR_W-1:0] pc
);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (penable && en) begin
      if (jmp) begin
        pc <= din;
      end else if (!stalled) begin
        if (pc == wrap_end)
          pc <= '0;            // Program wrap
        else
          pc <= pc + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/pio_scratch.sv
`timescale 1ns/100ps
`default_nettype none

module pio_scratch (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       penable,
  input  logic                       set,
  input  logic                       dec,
  input  logic [pio_pkg::DATA_W-1:0] din,
  output logic [pio_pkg::DATA_W-1:0] dout
);

  always_ff @(posedge clk) begin
    if (reset)
      dout <= '0;
    else if (penable) begin
      if (set)
        dout <= din;
      else if (dec)
        dout <= dout - 1'b1;   // Wraps to all ones from zero
    end
  end

endmodule

`default_nettype wire

//--- hw/pio_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module pio_shifter (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       penable,
  input  logic                       dir,          // 1 shifts right
  input  logic                       load,
  input  logic                       shift,
  input  logic [5:0]                 bit_count,    // 1 to 32
  input  logic [pio_pkg::DATA_W-1:0] din,
  output logic [pio_pkg::DATA_W-1:0] dout,
  output logic [pio_pkg::DATA_W-1:0] shifted_out
);

  logic [pio_pkg::DATA_W-1:0] mask;
  logic [pio_pkg::DATA_W-1:0] new_bits;
  logic [pio_pkg::DATA_W-1:0] next_val;
  logic [5:0]                 rest;

  // Shift by 32 yields zero, so a full count gives an all ones mask
  assign mask     = ~({pio_pkg::DATA_W{1'b1}} << bit_count);
  assign new_bits = din & mask;
  assign rest     = 6'd32 - bit_count;

  always_comb begin
    if (dir) begin
      // New bits enter at the top, departing bits leave at the bottom
      next_val    = (dout >> bit_count) | (new_bits << rest);
      shifted_out = dout & mask;
    end else begin
      next_val    = (dout << bit_count) | new_bits;
      shifted_out = dout >> rest;
    end
  end

  always_ff @(posedge clk) begin
    if (reset)
      dout <= '0;
    else if (penable) begin
      if (load)
        dout <= din;
      else if (shift)
        dout <= next_val;
    end
  end

endmodule

`default_nettype wire

//--- hw/pio_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module pio_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       write,
  input  logic                       read,
  input  logic [pio_pkg::DATA_W-1:0] wdata,
  output logic [pio_pkg::DATA_W-1:0] rdata,
  output logic                       full,
  output logic                       empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [pio_pkg::DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           count;

  assign rdata = mem[rd_ptr];
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (write)
      mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (write)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (read)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      if (write && !read)
        count <= count + 1'b1;
      else if (read && !write)
        count <= count - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/pio_machine.sv
`timescale 1ns/100ps
`default_nettype none

module pio_machine (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,
  input  logic [23:0] div,
  input  logic [15:0] instr,
  input  logic [4:0]  wrap_end,
  input  logic [31:0] input_pins,
  input  logic [31:0] tx_data,
  input  logic        tx_empty,
  input  logic        rx_full,
  input  logic [4:0]  pins_set_base,
  input  logic [2:0]  pins_set_count,
  input  logic        shift_dir,
  output logic [4:0]  pc,
  output logic        push,        // Write ISR to the receive FIFO
  output logic        pull,        // Pop the transmit FIFO into OSR
  output logic [31:0] rx_word,
  output logic [31:0] output_pins,
  output logic [31:0] pin_directions
);

  logic jmp, setx, sety, decx, decy;
  logic isr_load, isr_shift, osr_load, osr_shift;
  logic penable, blocked, stalled, fire;
  logic [31:0] new_val, isr_din, osr_din, src_val, mov_val, out_mask;
  logic [31:0] x, y, isr, osr, osr_out;
  pio_pkg::opcode_t  op;
  pio_pkg::src_dst_t dst, src_sel;
  logic [pio_pkg::OP1_W-1:0]   op1;
  logic [pio_pkg::OP2_W-1:0]   op2;
  logic [pio_pkg::DELAY_W-1:0] delay, delay_cnt;
  logic [5:0] bit_count;

  function automatic logic [31:0] bit_op(input logic [31:0] v, input pio_pkg::mov_op_t mop);
    case (mop)
      pio_pkg::INVERT:  return ~v;
      pio_pkg::REVERSE: return {<<{v}};
      default:          return v;
    endcase
  endfunction

  // Writes up to five immediate bits at base, wrapping modulo 32
  function automatic logic [31:0] set_field(input logic [31:0] vec, input logic [4:0] base,
                                            input logic [2:0] count, input logic [4:0] val);
    logic [31:0] res;
    logic [4:0]  idx;
    res = vec;
    for (int i = 0; i < 5; i++) begin
      idx = base + 5'(i);
      if (3'(i) < count)
        res[idx] = val[i];
    end
    return res;
  endfunction

  assign dst      = pio_pkg::src_dst_t'(op1);
  assign src_sel  = (op == pio_pkg::MOV) ? pio_pkg::src_dst_t'(op2[2:0]) : dst;
  assign mov_val  = bit_op(src_val, pio_pkg::mov_op_t'(op2[4:3]));
  assign out_mask = ~(32'hffff_ffff << bit_count);
  assign rx_word  = isr;

  always_comb begin
    case (src_sel)
      pio_pkg::PINS: src_val = input_pins;
      pio_pkg::X:    src_val = x;
      pio_pkg::Y:    src_val = y;
      pio_pkg::ISR:  src_val = isr;
      pio_pkg::OSR:  src_val = osr;
      default:       src_val = '0;
    endcase
  end

  assign blocked = ((op == pio_pkg::WAIT) && (input_pins[op2] != op1[2])) ||
                   ((op == pio_pkg::PUSHPULL) && (op1[2] ? tx_empty : rx_full));
  assign stalled = blocked || (delay_cnt != '0);
  assign fire    = en && penable && (delay_cnt == '0) && !blocked;

  always_comb begin
    {jmp, setx, sety, decx, decy, push, pull} = '0;
    {isr_load, isr_shift, osr_load, osr_shift} = '0;
    new_val = '0;
    isr_din = '0;
    osr_din = '0;
    if (fire) begin
      case (op)
        pio_pkg::JMP: begin
          case (op1)
            3'd0: jmp = 1'b1;
            3'd1: jmp = (x == '0);
            3'd2: begin jmp = (x != '0); decx = 1'b1; end
            3'd3: jmp = (y == '0);
            3'd4: begin jmp = (y != '0); decy = 1'b1; end
            3'd5: jmp = (x != y);
            3'd6: jmp = input_pins[0];  // Jump pin is input 0
            default: jmp = (osr != '0);
          endcase
        end
        pio_pkg::IN: begin
          isr_shift = 1'b1;
          isr_din   = src_val;
        end
        pio_pkg::OUT: begin
          osr_shift = 1'b1;
          new_val   = osr_out;
          setx      = (dst == pio_pkg::X);
          sety      = (dst == pio_pkg::Y);
        end
        pio_pkg::PUSHPULL: begin
          pull     = op1[2];
          push     = !op1[2];
          isr_load = !op1[2];       // ISR clears on push
          osr_load = op1[2];
          osr_din  = tx_data;
        end
        pio_pkg::MOV: begin
          new_val  = mov_val;
          setx     = (dst == pio_pkg::X);
          sety     = (dst == pio_pkg::Y);
          isr_load = (dst == pio_pkg::ISR);
          osr_load = (dst == pio_pkg::OSR);
          isr_din  = mov_val;
          osr_din  = mov_val;
        end
        pio_pkg::SET: begin
          new_val = {27'b0, op2};
          setx    = (dst == pio_pkg::X);
          sety    = (dst == pio_pkg::Y);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt      <= '0;
      output_pins    <= '0;
      pin_directions <= '0;
    end else begin
      if (en && penable) begin
        if (delay_cnt != '0)
          delay_cnt <= delay_cnt - 1'b1;
        else if (!blocked)
          delay_cnt <= delay;
      end
      if (fire && dst == pio_pkg::PINS) begin
        case (op)
          pio_pkg::OUT: output_pins <= (output_pins & ~out_mask) | (osr_out & out_mask);
          pio_pkg::MOV: output_pins <= mov_val;
          pio_pkg::SET: output_pins <= set_field(output_pins, pins_set_base,
                                                 pins_set_count, op2);
          default: ;
        endcase
      end
      if (fire && dst == pio_pkg::PINDIRS) begin
        case (op)
          pio_pkg::OUT: pin_directions <= (pin_directions & ~out_mask) | (osr_out & out_mask);
          pio_pkg::MOV: pin_directions <= mov_val;
          pio_pkg::SET: pin_directions <= set_field(pin_directions, pins_set_base,
                                                    pins_set_count, op2);
          default: ;
        endcase
      end
    end
  end

  pio_divider u_divider (.clk(clk), .reset(reset), .div(div), .penable(penable));

  pio_decoder u_decoder (
    .instr(instr), .op(op), .op1(op1), .op2(op2), .delay(delay), .bit_count(bit_count)
  );

  pio_pc u_pc (
    .clk(clk), .reset(reset), .penable(penable), .en(en), .jmp(jmp),
    .stalled(stalled), .din(op2), .wrap_end(wrap_end), .pc(pc)
  );

  pio_scratch u_x (
    .clk(clk), .reset(reset), .penable(penable),
    .set(setx), .dec(decx), .din(new_val), .dout(x)
  );

  pio_scratch u_y (
    .clk(clk), .reset(reset), .penable(penable),
    .set(sety), .dec(decy), .din(new_val), .dout(y)
  );

  pio_shifter u_isr (
    .clk(clk), .reset(reset), .penable(penable), .dir(shift_dir),
    .load(isr_load), .shift(isr_shift), .bit_count(bit_count),
    .din(isr_din), .dout(isr), .shifted_out()
  );

  pio_shifter u_osr (
    .clk(clk), .reset(reset), .penable(penable), .dir(shift_dir),
    .load(osr_load), .shift(osr_shift), .bit_count(bit_count),
    .din(osr_din), .dout(osr), .shifted_out(osr_out)
  );

endmodule

`default_nettype wire

//--- hw/pio_block.sv
`timescale 1ns/100ps
`default_nettype none

module pio_block #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        en,
  input  logic [23:0] div,
  input  logic        imem_we,
  input  logic [4:0]  imem_addr,
  input  logic [15:0] imem_data,
  input  logic [4:0]  wrap_end,
  input  logic        tx_write,
  input  logic [31:0] tx_data,
  input  logic        rx_read,
  input  logic [31:0] input_pins,
  input  logic [4:0]  pins_set_base,
  input  logic [2:0]  pins_set_count,
  input  logic        shift_dir,
  output logic        tx_full,
  output logic [31:0] rx_data,
  output logic        rx_empty,
  output logic [31:0] output_pins,
  output logic [31:0] pin_directions,
  output logic [4:0]  pc
);

  logic [pio_pkg::INSTR_W-1:0] imem [2**pio_pkg::ADDR_W];
  logic [pio_pkg::INSTR_W-1:0] instr;
  logic [31:0] tx_head, rx_word;
  logic        tx_empty, rx_full, push, pull;

  // Program is loaded only while the machine is stopped
  always_ff @(posedge clk) begin
    if (imem_we && !en)
      imem[imem_addr] <= imem_data;
  end

  assign instr = imem[pc];

  pio_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo (
    .clk(clk), .reset(reset), .write(tx_write && !tx_full), .read(pull),
    .wdata(tx_data), .rdata(tx_head), .full(tx_full), .empty(tx_empty)
  );

  pio_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo (
    .clk(clk), .reset(reset), .write(push), .read(rx_read && !rx_empty),
    .wdata(rx_word), .rdata(rx_data), .full(rx_full), .empty(rx_empty)
  );

  pio_machine u_machine (
    .clk(clk), .reset(reset), .en(en), .div(div), .instr(instr),
    .wrap_end(wrap_end), .input_pins(input_pins), .tx_data(tx_head),
    .tx_empty(tx_empty), .rx_full(rx_full), .pins_set_base(pins_set_base),
    .pins_set_count(pins_set_count), .shift_dir(shift_dir), .pc(pc),
    .push(push), .pull(pull), .rx_word(rx_word), .output_pins(output_pins),
    .pin_directions(pin_directions)
  );

endmodule

`default_nettype wire

//--- testbench/pio_block_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module pio_block_asserts (
  input logic       clk,
  input logic       reset,
  input logic       push,
  input logic       pull,
  input logic       rx_full,
  input logic       tx_empty,
  input logic [4:0] pc
);

  push_not_full: assert property (@(posedge clk) disable iff (reset) !(push && rx_full))
    else $error("push while receive FIFO full");

  pull_not_empty: assert property (@(posedge clk) disable iff (reset) !(pull && tx_empty))
    else $error("pull while transmit FIFO empty");

  // First cycle out of reset
  pc_after_reset: assert property (@(posedge clk) $fell(reset) |-> pc == '0)
    else $error("pc not zero after reset");

endmodule

bind pio_machine pio_block_asserts u_asserts (
  .clk(clk), .reset(reset), .push(push), .pull(pull),
  .rx_full(rx_full), .tx_empty(tx_empty), .pc(pc)
);

`default_nettype wire

//--- testbench/pio_block_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pio_block_tb;

  localparam int FIFO_DEPTH = 4;
  localparam int TIMEOUT    = 2000;  // Cycles per wait
  localparam int FULL_HOLD  = 8;     // Longer than one pass of the datapath program

  logic        clk, reset, en, imem_we, tx_write, rx_read, shift_dir;
  logic        tx_full, rx_empty;
  logic [23:0] div;
  logic [4:0]  imem_addr, wrap_end, pins_set_base, pc;
  logic [2:0]  pins_set_count;
  logic [15:0] imem_data;
  logic [31:0] tx_data, input_pins, rx_data, output_pins, pin_directions;
  logic [31:0] model_pins, model_dirs;
  logic [31:0] tx_q[$];
  logic [31:0] exp_q[$];
  integer      seed = 58;
  int          error_count;

  pio_block #(.FIFO_DEPTH(FIFO_DEPTH)) u_pio_block (
    .clk(clk), .reset(reset), .en(en), .div(div), .imem_we(imem_we),
    .imem_addr(imem_addr), .imem_data(imem_data), .wrap_end(wrap_end),
    .tx_write(tx_write), .tx_data(tx_data), .rx_read(rx_read),
    .input_pins(input_pins), .pins_set_base(pins_set_base),
    .pins_set_count(pins_set_count), .shift_dir(shift_dir), .tx_full(tx_full),
    .rx_data(rx_data), .rx_empty(rx_empty), .output_pins(output_pins),
    .pin_directions(pin_directions), .pc(pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    error_count++;
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
      fail_run($sformatf("Error at %0t: received word %h, expected %h", $time, got, exp));
  endtask

  task automatic check_pins(input logic [31:0] got, input logic [31:0] exp, input string name);
    if (got !== exp)
      fail_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  // FIFO back-pressure seen from outside the machine
  always @(negedge clk) begin
    if (!reset && u_pio_block.u_machine.push && u_pio_block.rx_full)
      fail_run("Machine pushed into a full receive FIFO");
    if (!reset && u_pio_block.u_machine.pull && u_pio_block.tx_empty)
      fail_run("Machine pulled from an empty transmit FIFO");
  end

  function automatic logic [15:0] encode(input pio_pkg::opcode_t op, input logic [4:0] delay,
                                         input logic [2:0] op1, input logic [4:0] op2);
    return {op, delay, op1, op2};
  endfunction

  function automatic logic [31:0] mov_result(input logic [31:0] w, input pio_pkg::mov_op_t mop);
    logic [31:0] r;
    for (int i = 0; i < 32; i++)
      r[i] = w[31 - i];
    case (mop)
      pio_pkg::INVERT:  return ~w;
      pio_pkg::REVERSE: return r;
      default:          return w;
    endcase
  endfunction

  function automatic logic [31:0] place_bits(input logic [31:0] vec, input int base,
                                             input int count, input logic [4:0] val);
    logic [31:0] r;
    r = vec;
    for (int i = 0; i < count && i < 5; i++)
      r[(base + i) % 32] = val[i];
    return r;
  endfunction

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    en    = 1'b0;
    repeat (4) @(negedge clk);
    reset      = 1'b0;
    model_pins = '0;
    model_dirs = '0;
    if (pc !== 5'd0)
      fail_run("Program counter is not zero after reset");
    if (tx_full !== 1'b0 || rx_empty !== 1'b1)
      fail_run("FIFOs are not empty after reset");
  endtask

  task automatic wait_pc(input logic [4:0] target);
    int cycles;
    cycles = 0;
    while (pc !== target) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT)
        fail_run($sformatf("Timed out waiting for pc to reach %0d", target));
    end
  endtask

  task automatic load_word(input logic [4:0] addr, input logic [15:0] word);
    @(negedge clk);
    imem_we   = 1'b1;
    imem_addr = addr;
    imem_data = word;
    @(negedge clk);
    imem_we = 1'b0;
  endtask

  // Feeds tx_q and checks every received word against exp_q
  task automatic run_stream(input bit hold);
    int cycles;
    int full_cycles;
    bit draining;
    cycles      = 0;
    full_cycles = 0;
    draining    = !hold;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      tx_write = 1'b0;
      rx_read  = 1'b0;
      if (tx_q.size() > 0 && !tx_full) begin
        tx_write = 1'b1;
        tx_data  = tx_q.pop_front();
      end
      if (u_pio_block.rx_full)
        full_cycles++;
      if (full_cycles > FULL_HOLD)
        draining = 1'b1;      // Machine has been stalled on PUSH by now
      if (draining && !rx_empty) begin
        check_word(rx_data, exp_q.pop_front());
        rx_read = 1'b1;
      end
      cycles++;
      if (cycles > TIMEOUT)
        fail_run("Timed out waiting for received words");
    end
    @(negedge clk);
    tx_write = 1'b0;
    rx_read  = 1'b0;
  endtask

  // WAIT gate, then SET PINS and SET PINDIRS, then back to the WAIT
  task automatic set_pins_test();
    logic [31:0] r;
    logic [4:0]  pin, imm_p, imm_d;
    logic        pol;
    int          hold_cycles;
    r     = $random(seed);
    pin   = r[4:0];
    pol   = r[5];
    imm_p = r[10:6];
    imm_d = r[15:11];
    @(negedge clk);
    en             = 1'b0;
    input_pins     = $random(seed);
    input_pins[pin] = !pol;
    pins_set_base  = r[20:16];
    pins_set_count = r[23:21] % 3'd6;
    wrap_end       = 5'd31;
    load_word(0, encode(pio_pkg::WAIT, 0, {pol, 2'b00}, pin));
    load_word(1, encode(pio_pkg::SET, 0, pio_pkg::PINS, imm_p));
    load_word(2, encode(pio_pkg::SET, 0, pio_pkg::PINDIRS, imm_d));
    load_word(3, encode(pio_pkg::JMP, 0, 3'd0, 5'd0));
    hold_cycles = 3 + $unsigned($random(seed)) % 8;
    @(negedge clk);
    en = 1'b1;
    repeat (hold_cycles) begin
      @(negedge clk);
      check_pins(output_pins, model_pins, "output_pins");
    end
    input_pins[pin] = pol;
    wait_pc(1);
    input_pins[pin] = !pol;     // Close the gate for the next pass
    check_pins(output_pins, model_pins, "output_pins");
    model_pins = place_bits(model_pins, pins_set_base, pins_set_count, imm_p);
    model_dirs = place_bits(model_dirs, pins_set_base, pins_set_count, imm_d);
    wait_pc(3);
    check_pins(output_pins, model_pins, "output_pins");
    check_pins(pin_directions, model_dirs, "pin_directions");
    en = 1'b0;
  endtask

  task automatic run_datapath(input int words, input bit hold, input logic [4:0] dly);
    logic [31:0]       r;
    logic [31:0]       w;
    pio_pkg::mov_op_t  mop;
    r   = $unsigned($random(seed)) % 3;
    mop = pio_pkg::mov_op_t'(r[1:0]);
    r   = $random(seed);
    @(negedge clk);
    en        = 1'b0;
    shift_dir = r[0];
    wrap_end  = 5'd4;
    load_word(0, encode(pio_pkg::PUSHPULL, 0, 3'b100, 0));   // PULL
    load_word(1, encode(pio_pkg::OUT, 0, pio_pkg::X, 0));
    load_word(2, encode(pio_pkg::MOV, dly, pio_pkg::Y, {mop, pio_pkg::X}));
    load_word(3, encode(pio_pkg::IN, dly, pio_pkg::Y, 0));
    load_word(4, encode(pio_pkg::PUSHPULL, 0, 3'b000, 0));   // PUSH
    for (int i = 0; i < words; i++) begin
      w = $random(seed);
      tx_q.push_back(w);
      exp_q.push_back(mov_result(w, mop));
    end
    @(negedge clk);
    en = 1'b1;
    run_stream(hold);
    wait_pc(0);
  endtask

  task automatic count_down_loop();
    logic [31:0] r;
    logic [4:0]  n;
    r = $random(seed);
    n = {1'b0, r[3:0]};
    apply_reset();
    wrap_end = 5'd31;
    load_word(0, encode(pio_pkg::SET, 0, pio_pkg::X, n));
    load_word(1, encode(pio_pkg::IN, 0, pio_pkg::X, 0));
    load_word(2, encode(pio_pkg::PUSHPULL, 0, 3'b000, 0));
    load_word(3, encode(pio_pkg::JMP, 0, 3'd2, 5'd1));       // X-- back to IN
    load_word(4, encode(pio_pkg::JMP, 0, 3'd0, 5'd4));       // Halt
    for (int i = n; i >= 0; i--)
      exp_q.push_back(i);
    @(negedge clk);
    en = 1'b1;
    run_stream(1'b0);
    wait_pc(4);
    if (!rx_empty)
      fail_run("Loop produced more words than expected");
    en = 1'b0;
  endtask

  initial begin
    reset          = 1'b1;
    en             = 1'b0;
    div            = 24'd256;
    imem_we        = 1'b0;
    imem_addr      = '0;
    imem_data      = '0;
    wrap_end       = 5'd31;
    tx_write       = 1'b0;
    tx_data        = '0;
    rx_read        = 1'b0;
    input_pins     = '0;
    pins_set_base  = '0;
    pins_set_count = '0;
    shift_dir      = 1'b0;
    error_count    = 0;
    apply_reset();
    repeat (6) set_pins_test();
    apply_reset();
    repeat (4) run_datapath(6, 1'b0, 5'd0);
    repeat (2) count_down_loop();
    apply_reset();
    run_datapath(12, 1'b1, 5'd0);    // Receive FIFO fills before draining
    div = 24'd512;                   // Half rate
    apply_reset();
    run_datapath(6, 1'b0, 5'd3);
    @(negedge clk);
    if (error_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

//--- pio_block.f
hw/pio_pkg.sv
hw/pio_divider.sv
hw/pio_decoder.sv
hw/pio_pc.sv
hw/pio_scratch.sv
hw/pio_shifter.sv
hw/pio_fifo.sv
hw/pio_machine.sv
hw/pio_block.sv
testbench/pio_block_asserts.sv
testbench/pio_block_tb.sv
